// ==== tile_settings.svh ====
`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

// Message widths
`define TILE_ADDR_WIDTH 16
`define TILE_DATA_WIDTH 32
`define TILE_DID_WIDTH 8

// Local devices sit below the DRAM base
`define TILE_DRAM_BASE 16'h8000
`define TILE_DEV_LSB 12

// Sizes
`define TILE_RAM_WORDS 64
`define TILE_FIFO_DEPTH 2
`define TILE_NUM_DEV 4

`endif

// ==== tile_pkg.sv ====
`include "tile_settings.svh"

package tile_pkg;

  typedef enum logic
  {
    e_op_rd = 1'b0,
    e_op_wr = 1'b1
  } opcode_e;

  // Device ports of the router and arbiter
  typedef enum logic [1:0]
  {
    e_dev_mem   = 2'd0,
    e_dev_cfg   = 2'd1,
    e_dev_clint = 2'd2,
    e_dev_loop  = 2'd3
  } dev_e;

  // Device field codes of a local address
  typedef enum logic [2:0]
  {
    e_local_mem   = 3'd0,
    e_local_cfg   = 3'd1,
    e_local_clint = 3'd2
  } local_dev_e;

  typedef struct packed
  {
    opcode_e                     opcode;
    logic [`TILE_ADDR_WIDTH-1:0] addr;
    logic [`TILE_DATA_WIDTH-1:0] data;
  } cmd_msg_s;

  typedef struct packed
  {
    opcode_e                     opcode;
    logic [`TILE_ADDR_WIDTH-1:0] addr;
    logic [`TILE_DATA_WIDTH-1:0] data;
  } resp_msg_s;

endpackage

// ==== mem_dev_if.sv ====
interface mem_dev_if;

  logic                cmd_v;
  logic                cmd_ready_and;
  tile_pkg::cmd_msg_s  cmd;

  logic                resp_v;
  logic                resp_ready_and;
  tile_pkg::resp_msg_s resp;

  modport router
  (
    output cmd_v, cmd,
    input  cmd_ready_and
  );

  modport device
  (
    input  cmd_v, cmd, resp_ready_and,
    output cmd_ready_and, resp_v, resp
  );

  modport arbiter
  (
    input  resp_v, resp,
    output resp_ready_and
  );

endinterface

// ==== stream_fifo.sv ====
module stream_fifo
  #(parameter type payload_t = logic
    , parameter int depth = 2
    )
  (input              clk_i
   , input            rst_n_i

   , input            in_v_i
   , output logic     in_ready_and_o
   , input payload_t  in_data_i

   , output logic     out_v_o
   , input            out_ready_and_i
   , output payload_t out_data_o
   );

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t mem_r [depth];
  logic [ptr_w-1:0] wr_ptr_r, rd_ptr_r;
  logic [cnt_w-1:0] count_r;
  logic push, pop;

  assign in_ready_and_o = (count_r != cnt_w'(depth));
  assign out_v_o        = (count_r != '0);
  assign out_data_o     = mem_r[rd_ptr_r];

  assign push = in_v_i & in_ready_and_o;
  assign pop  = out_v_o & out_ready_and_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= (wr_ptr_r == ptr_w'(depth - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == ptr_w'(depth - 1)) ? '0 : rd_ptr_r + 1'b1;
      // Simultaneous push and pop leaves the count alone
      if (push && !pop)
        count_r <= count_r + 1'b1;
      else if (pop && !push)
        count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wr_ptr_r] <= in_data_i;
  end

endmodule

// ==== dev_ram.sv ====
`include "tile_settings.svh"

module dev_ram
  (input                clk_i
   , input              rst_n_i

   , mem_dev_if.device  dev
   );

  localparam int idx_w = $clog2(`TILE_RAM_WORDS);

  logic [`TILE_DATA_WIDTH-1:0] mem_r [`TILE_RAM_WORDS];
  logic [idx_w-1:0]            idx;
  logic                        resp_v_r;
  tile_pkg::resp_msg_s         resp_r;
  logic                        accept, is_wr;

  // High address bits are dropped, so local and DRAM windows alias
  assign idx   = dev.cmd.addr[2 +: idx_w];
  assign is_wr = (dev.cmd.opcode == tile_pkg::e_op_wr);

  assign dev.cmd_ready_and = ~resp_v_r | dev.resp_ready_and;
  assign accept            = dev.cmd_v & dev.cmd_ready_and;
  assign dev.resp_v        = resp_v_r;
  assign dev.resp          = resp_r;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_r <= 1'b0;
      mem_r    <= '{default: '0};
    end
    else
    begin
      if (accept)
        resp_v_r <= 1'b1;
      else if (dev.resp_ready_and)
        resp_v_r <= 1'b0;
      if (accept && is_wr)
        mem_r[idx] <= dev.cmd.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_r <= '{opcode: dev.cmd.opcode, addr: dev.cmd.addr, data: is_wr ? '0 : mem_r[idx]};
  end

endmodule

// ==== tile_cfg.sv ====
`include "tile_settings.svh"

module tile_cfg
  (input                              clk_i
   , input                            rst_n_i

   , mem_dev_if.device                dev

   , input [`TILE_DID_WIDTH-1:0]      did_i
   , output logic                     freeze_o
   );

  logic [`TILE_DEV_LSB-3:0]    offset;
  logic [`TILE_DATA_WIDTH-1:0] scratch_r;
  logic [`TILE_DATA_WIDTH-1:0] rd_data;
  logic                        freeze_r;
  logic                        resp_v_r;
  tile_pkg::resp_msg_s         resp_r;
  logic                        accept, is_wr;

  assign offset = dev.cmd.addr[`TILE_DEV_LSB-1:2];
  assign is_wr  = (dev.cmd.opcode == tile_pkg::e_op_wr);

  // One response held, refilled as it drains
  assign dev.cmd_ready_and = ~resp_v_r | dev.resp_ready_and;
  assign accept            = dev.cmd_v & dev.cmd_ready_and;
  assign dev.resp_v        = resp_v_r;
  assign dev.resp          = resp_r;
  assign freeze_o          = freeze_r;

  always_comb
  begin
    case (offset)
      'd0:     rd_data = `TILE_DATA_WIDTH'(did_i);
      'd1:     rd_data = scratch_r;
      'd2:     rd_data = `TILE_DATA_WIDTH'(freeze_r);
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_r  <= 1'b0;
      scratch_r <= '0;
      freeze_r  <= 1'b1;
    end
    else
    begin
      if (accept)
        resp_v_r <= 1'b1;
      else if (dev.resp_ready_and)
        resp_v_r <= 1'b0;
      if (accept && is_wr && offset == 'd1)
        scratch_r <= dev.cmd.data;
      if (accept && is_wr && offset == 'd2)
        freeze_r <= dev.cmd.data[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_r <= '{opcode: dev.cmd.opcode, addr: dev.cmd.addr, data: is_wr ? '0 : rd_data};
  end

endmodule

// ==== clint_slice.sv ====
`include "tile_settings.svh"

module clint_slice
  (input                 clk_i
   , input               rst_n_i

   , mem_dev_if.device   dev

   , output logic        timer_irq_o
   , output logic        software_irq_o
   );

  logic [`TILE_DEV_LSB-3:0]    offset;
  logic [`TILE_DATA_WIDTH-1:0] mtime_r;
  logic [`TILE_DATA_WIDTH-1:0] mtimecmp_r;
  logic [`TILE_DATA_WIDTH-1:0] rd_data;
  logic                        msip_r;
  logic                        timer_irq_r;
  logic                        resp_v_r;
  tile_pkg::resp_msg_s         resp_r;
  logic                        accept, is_wr;

  assign offset = dev.cmd.addr[`TILE_DEV_LSB-1:2];
  assign is_wr  = (dev.cmd.opcode == tile_pkg::e_op_wr);

  assign dev.cmd_ready_and = ~resp_v_r | dev.resp_ready_and;
  assign accept            = dev.cmd_v & dev.cmd_ready_and;
  assign dev.resp_v        = resp_v_r;
  assign dev.resp          = resp_r;

  assign software_irq_o = msip_r;
  assign timer_irq_o    = timer_irq_r;

  always_comb
  begin
    case (offset)
      'd0:     rd_data = `TILE_DATA_WIDTH'(msip_r);
      'd1:     rd_data = mtimecmp_r;
      'd2:     rd_data = mtime_r;
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_r    <= 1'b0;
      msip_r      <= 1'b0;
      mtimecmp_r  <= '1;
      mtime_r     <= '0;
      timer_irq_r <= 1'b0;
    end
    else
    begin
      if (accept)
        resp_v_r <= 1'b1;
      else if (dev.resp_ready_and)
        resp_v_r <= 1'b0;

      if (accept && is_wr && offset == 'd0)
        msip_r <= dev.cmd.data[0];
      if (accept && is_wr && offset == 'd1)
        mtimecmp_r <= dev.cmd.data;

      // A write to mtime replaces this cycle's increment
      if (accept && is_wr && offset == 'd2)
        mtime_r <= dev.cmd.data;
      else
        mtime_r <= mtime_r + 1'b1;

      timer_irq_r <= (mtime_r >= mtimecmp_r);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_r <= '{opcode: dev.cmd.opcode, addr: dev.cmd.addr, data: is_wr ? '0 : rd_data};
  end

endmodule

// ==== mem_loopback.sv ====
module mem_loopback
  (input                clk_i
   , input              rst_n_i

   , mem_dev_if.device  dev
   );

  logic                resp_v_r;
  tile_pkg::resp_msg_s resp_r;
  logic                accept;

  assign dev.cmd_ready_and = ~resp_v_r | dev.resp_ready_and;
  assign accept            = dev.cmd_v & dev.cmd_ready_and;
  assign dev.resp_v        = resp_v_r;
  assign dev.resp          = resp_r;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (dev.resp_ready_and)
      resp_v_r <= 1'b0;
  end

  // Echo the header with zero data
  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_r <= '{opcode: dev.cmd.opcode, addr: dev.cmd.addr, data: '0};
  end

endmodule

// ==== cmd_router.sv ====
`include "tile_settings.svh"

module cmd_router
  (input                        clk_i
   , input                      rst_n_i

   , input                      cmd_v_i
   , output logic               cmd_ready_and_o
   , input tile_pkg::cmd_msg_s  cmd_i

   , mem_dev_if.router          dev [`TILE_NUM_DEV]
   );

  localparam int num_dev = `TILE_NUM_DEV;
  localparam int field_w = $bits(tile_pkg::local_dev_e);

  tile_pkg::cmd_msg_s   head;
  logic                 head_v;
  tile_pkg::dev_e       sel;
  tile_pkg::local_dev_e local_dev;
  logic [num_dev-1:0]   dev_ready;

  stream_fifo
   #(.payload_t(tile_pkg::cmd_msg_s)
     ,.depth(`TILE_FIFO_DEPTH)
     )
   cmd_fifo
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.in_v_i(cmd_v_i)
     ,.in_ready_and_o(cmd_ready_and_o)
     ,.in_data_i(cmd_i)
     ,.out_v_o(head_v)
     ,.out_ready_and_i(dev_ready[sel])
     ,.out_data_o(head)
     );

  // Address decode of the head command
  assign local_dev = tile_pkg::local_dev_e'(head.addr[`TILE_DEV_LSB +: field_w]);

  always_comb
  begin
    if (head.addr >= `TILE_ADDR_WIDTH'(`TILE_DRAM_BASE))
      sel = tile_pkg::e_dev_mem;
    else
    begin
      case (local_dev)
        tile_pkg::e_local_mem:   sel = tile_pkg::e_dev_mem;
        tile_pkg::e_local_cfg:   sel = tile_pkg::e_dev_cfg;
        tile_pkg::e_local_clint: sel = tile_pkg::e_dev_clint;
        default:                 sel = tile_pkg::e_dev_loop;
      endcase
    end
  end

  // Only the selected device sees a valid command
  for (genvar i = 0; i < num_dev; i++)
  begin : steer
    assign dev[i].cmd_v  = head_v & (sel == tile_pkg::dev_e'(i));
    assign dev[i].cmd    = head;
    assign dev_ready[i]  = dev[i].cmd_ready_and;
  end

endmodule

// ==== resp_arbiter.sv ====
`include "tile_settings.svh"

module resp_arbiter
  (input                                clk_i
   , input                              rst_n_i

   , mem_dev_if.arbiter                 dev [`TILE_NUM_DEV]

   , output logic                       resp_v_o
   , input                              resp_ready_and_i
   , output tile_pkg::resp_msg_s        resp_o
   );

  localparam int num_dev = `TILE_NUM_DEV;
  localparam int sel_w   = $clog2(num_dev);

  logic [num_dev-1:0]  resp_v;
  tile_pkg::resp_msg_s resp_data [num_dev];
  logic [sel_w-1:0]    last_r;
  logic [sel_w-1:0]    grant;
  logic                grant_v;
  logic                fifo_ready;

  for (genvar i = 0; i < num_dev; i++)
  begin : gather
    assign resp_v[i]    = dev[i].resp_v;
    assign resp_data[i] = dev[i].resp;
    // Acknowledge the winner only
    assign dev[i].resp_ready_and = fifo_ready & grant_v & (grant == sel_w'(i));
  end

  // Search starts one past the last winner
  always_comb
  begin
    logic [sel_w-1:0] idx;
    grant_v = 1'b0;
    grant   = last_r;
    for (int k = 1; k <= num_dev; k++)
    begin
      idx = sel_w'((int'(last_r) + k) % num_dev);
      if (!grant_v && resp_v[idx])
      begin
        grant_v = 1'b1;
        grant   = idx;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      last_r <= sel_w'(num_dev - 1);
    else if (grant_v && fifo_ready)
      last_r <= grant;
  end

  stream_fifo
   #(.payload_t(tile_pkg::resp_msg_s)
     ,.depth(`TILE_FIFO_DEPTH)
     )
   resp_fifo
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.in_v_i(grant_v)
     ,.in_ready_and_o(fifo_ready)
     ,.in_data_i(resp_data[grant])
     ,.out_v_o(resp_v_o)
     ,.out_ready_and_i(resp_ready_and_i)
     ,.out_data_o(resp_o)
     );

endmodule

// ==== mem_tile.sv ====
`include "tile_settings.svh"

module mem_tile
  (input                                clk_i
   , input                              rst_n_i

   , input                              cmd_v_i
   , output logic                       cmd_ready_o
   , input                              cmd_opcode_i
   , input [`TILE_ADDR_WIDTH-1:0]       cmd_addr_i
   , input [`TILE_DATA_WIDTH-1:0]       cmd_data_i

   , output logic                       resp_v_o
   , input                              resp_ready_i
   , output logic                       resp_opcode_o
   , output logic [`TILE_ADDR_WIDTH-1:0] resp_addr_o
   , output logic [`TILE_DATA_WIDTH-1:0] resp_data_o

   , input [`TILE_DID_WIDTH-1:0]        did_i
   , output logic                       freeze_o
   , output logic                       timer_irq_o
   , output logic                       software_irq_o
   );

  tile_pkg::cmd_msg_s  cmd_li;
  tile_pkg::resp_msg_s resp_lo;

  // One bundle per device, indexed by dev_e
  mem_dev_if dev_if [`TILE_NUM_DEV] ();

  assign cmd_li = '{opcode: tile_pkg::opcode_e'(cmd_opcode_i)
                    , addr: cmd_addr_i
                    , data: cmd_data_i
                    };

  assign resp_opcode_o = resp_lo.opcode;
  assign resp_addr_o   = resp_lo.addr;
  assign resp_data_o   = resp_lo.data;

  cmd_router router
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_and_o(cmd_ready_o)
     ,.cmd_i(cmd_li)
     ,.dev(dev_if)
     );

  dev_ram ram
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.dev(dev_if[tile_pkg::e_dev_mem])
     );

  tile_cfg cfg
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.dev(dev_if[tile_pkg::e_dev_cfg])
     ,.did_i(did_i)
     ,.freeze_o(freeze_o)
     );

  clint_slice clint
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.dev(dev_if[tile_pkg::e_dev_clint])
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  mem_loopback loopback
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.dev(dev_if[tile_pkg::e_dev_loop])
     );

  resp_arbiter arbiter
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.dev(dev_if)
     ,.resp_v_o(resp_v_o)
     ,.resp_ready_and_i(resp_ready_i)
     ,.resp_o(resp_lo)
     );

endmodule

// ==== tb_mem_tile.sv ====
`include "tile_settings.svh"

module tb_mem_tile;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int aw            = `TILE_ADDR_WIDTH;
  localparam int dw            = `TILE_DATA_WIDTH;
  localparam int ram_cmds      = 200;
  localparam int directed_cmds = 15;
  localparam int mix_cmds      = 200;
  localparam int cycle_limit   = 20 * (ram_cmds + directed_cmds + mix_cmds) + 500;

  typedef struct packed
  {
    logic          is_mtime;
    logic          opcode;
    logic [aw-1:0] addr;
    logic [dw-1:0] data;
  } expect_s;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       cmd_v_i;
  logic                       cmd_ready_o;
  logic                       cmd_opcode_i;
  logic [aw-1:0]              cmd_addr_i;
  logic [dw-1:0]              cmd_data_i;
  logic                       resp_v_o;
  logic                       resp_ready_i;
  logic                       resp_opcode_o;
  logic [aw-1:0]              resp_addr_o;
  logic [dw-1:0]              resp_data_o;
  logic [`TILE_DID_WIDTH-1:0] did_i;
  logic                       freeze_o;
  logic                       timer_irq_o;
  logic                       software_irq_o;

  // Reference model state
  logic [dw-1:0] ram_m [`TILE_RAM_WORDS];
  logic [dw-1:0] scratch_m;
  logic          freeze_m;
  logic          msip_m;
  logic [dw-1:0] mtimecmp_m;
  logic [dw-1:0] last_mtime;
  expect_s       exp_q [`TILE_NUM_DEV][$];

  logic [31:0] lfsr_r;
  logic        rand_ready;
  int          cmd_count = 0;
  int          resp_count = 0;
  int          checks = 0;
  int          errors = 0;
  int          errors_at_start = 0;
  int          cycles = 0;

  mem_tile mem_tile_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial
  begin
    while (cycles < cycle_limit)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Run stopped after %0d cycles before the tests finished", cycles);
    $display("Test failed");
    $finish;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
    lfsr_r = {lfsr_r[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  // Port index 0 is mem, 1 cfg, 2 clint and 3 loopback
  function automatic int dev_of(input logic [aw-1:0] addr);
    logic [2:0] code;
    code = addr[`TILE_DEV_LSB +: 3];
    if (addr >= `TILE_DRAM_BASE)
      return 0;
    else if (code <= 3'd2)
      return int'(code);
    else
      return 3;
  endfunction

  function automatic logic [aw-1:0] local_addr(input int code, input int offset);
    return aw'(code << `TILE_DEV_LSB) | aw'(offset << 2);
  endfunction

  task automatic compare_value(input string name, input logic [dw-1:0] expected,
                               input logic [dw-1:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic require(input logic cond, input string text);
    checks++;
    assert (cond)
    else
    begin
      errors++;
      $display("Error at %0d ns: %s", $time, text);
    end
  endtask

  task automatic end_test(input string name);
    $display("%-24s finished, %0d errors", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  // Update the model and queue the expected response
  task automatic model_cmd(input logic op, input logic [aw-1:0] addr, input logic [dw-1:0] data);
    expect_s e;
    int      d;
    int      offset;
    d      = dev_of(addr);
    offset = int'(addr[`TILE_DEV_LSB-1:2]);
    e      = '{is_mtime: 1'b0, opcode: op, addr: addr, data: '0};
    case (d)
      0:
      begin
        if (op)
          ram_m[addr[7:2]] = data;
        else
          e.data = ram_m[addr[7:2]];
      end
      1:
      begin
        if (op && offset == 1)
          scratch_m = data;
        else if (op && offset == 2)
          freeze_m = data[0];
        else if (!op && offset == 0)
          e.data = dw'(did_i);
        else if (!op && offset == 1)
          e.data = scratch_m;
        else if (!op && offset == 2)
          e.data = dw'(freeze_m);
      end
      2:
      begin
        if (op && offset == 0)
          msip_m = data[0];
        else if (op && offset == 1)
          mtimecmp_m = data;
        else if (!op && offset == 0)
          e.data = dw'(msip_m);
        else if (!op && offset == 1)
          e.data = mtimecmp_m;
        else if (!op && offset == 2)
          e.is_mtime = 1'b1;
      end
      default:
        e.data = '0;
    endcase
    exp_q[d].push_back(e);
    cmd_count++;
  endtask

  task automatic score_response();
    expect_s e;
    int      d;
    d = dev_of(resp_addr_o);
    resp_count++;
    require(exp_q[d].size() != 0, "response arrived with no command waiting for it");
    if (exp_q[d].size() != 0)
    begin
      e = exp_q[d].pop_front();
      compare_value("resp_opcode_o", dw'(e.opcode), dw'(resp_opcode_o));
      compare_value("resp_addr_o", dw'(e.addr), dw'(resp_addr_o));
      if (e.is_mtime)
      begin
        checks++;
        assert (resp_data_o > last_mtime)
        else
        begin
          errors++;
          $display("** Error at %0d ns: resp_data_o (mtime) expected above %h, got %h",
                   $time, last_mtime, resp_data_o);
        end
        last_mtime = resp_data_o;
      end
      else
        compare_value("resp_data_o", e.data, resp_data_o);
    end
  endtask

  // Handshake signals are stable at the falling edge
  always @(negedge clk_i)
  begin
    if (rst_n_i && resp_v_o && resp_ready_i)
      score_response();
  end

  task automatic step();
    @(posedge clk_i);
    #2;
    if (rand_ready)
      resp_ready_i = (rand_bits(2) != 0);
  endtask

  task automatic send_cmd(input logic op, input logic [aw-1:0] addr, input logic [dw-1:0] data);
    logic taken;
    cmd_v_i      = 1'b1;
    cmd_opcode_i = op;
    cmd_addr_i   = addr;
    cmd_data_i   = data;
    taken        = 1'b0;
    while (!taken)
    begin
      @(negedge clk_i);
      taken = cmd_ready_o;
      step();
    end
    model_cmd(op, addr, data);
    cmd_v_i = 1'b0;
  endtask

  task automatic drain();
    rand_ready   = 1'b0;
    resp_ready_i = 1'b1;
    while (resp_count != cmd_count)
      step();
  endtask

  initial
  begin
    logic          op;
    logic [aw-1:0] addr;
    logic [dw-1:0] data;
    int            n;

    lfsr_r       = 32'ha582;
    rst_n_i      = 1'b0;
    cmd_v_i      = 1'b0;
    cmd_opcode_i = 1'b0;
    cmd_addr_i   = '0;
    cmd_data_i   = '0;
    resp_ready_i = 1'b1;
    did_i        = 8'h5a;
    rand_ready   = 1'b0;
    scratch_m    = '0;
    freeze_m     = 1'b1;
    msip_m       = 1'b0;
    mtimecmp_m   = '1;
    last_mtime   = '0;
    for (int i = 0; i < `TILE_RAM_WORDS; i++)
      ram_m[i] = '0;

    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    compare_value("resp_v_o", '0, dw'(resp_v_o));
    compare_value("cmd_ready_o", 32'd1, dw'(cmd_ready_o));
    compare_value("freeze_o", 32'd1, dw'(freeze_o));
    compare_value("timer_irq_o", '0, dw'(timer_irq_o));
    compare_value("software_irq_o", '0, dw'(software_irq_o));
    end_test("Reset state");

    // Local device 0 and DRAM share the RAM index
    for (int k = 0; k < ram_cmds; k++)
    begin
      op = 1'(rand_bits(1));
      if (rand_bits(1) != 0)
        addr = `TILE_DRAM_BASE | 16'(rand_bits(15));
      else
        addr = 16'(rand_bits(12));
      data = rand_bits(32);
      send_cmd(op, addr, data);
    end
    drain();
    end_test("RAM");

    send_cmd(1'b0, local_addr(1, 0), '0);
    send_cmd(1'b1, local_addr(1, 1), rand_bits(32));
    send_cmd(1'b0, local_addr(1, 1), '0);
    send_cmd(1'b1, local_addr(1, 2), '0);
    drain();
    compare_value("freeze_o", '0, dw'(freeze_o));
    send_cmd(1'b0, local_addr(1, 2), '0);
    send_cmd(1'b0, local_addr(1, 3), '0);
    send_cmd(1'b0, local_addr(1, 1023), '0);
    drain();
    end_test("Config registers");

    send_cmd(1'b1, local_addr(2, 0), 32'd1);
    drain();
    compare_value("software_irq_o", 32'd1, dw'(software_irq_o));
    compare_value("timer_irq_o", '0, dw'(timer_irq_o));
    send_cmd(1'b0, local_addr(2, 0), '0);
    send_cmd(1'b0, local_addr(2, 2), '0);
    drain();
    send_cmd(1'b1, local_addr(2, 1), last_mtime + 32'd50);
    drain();
    n = 0;
    while (!timer_irq_o && n < 100)
    begin
      step();
      n++;
    end
    require(timer_irq_o == 1'b1, "timer_irq_o did not rise within 100 cycles of the mtimecmp write");
    repeat (3) send_cmd(1'b0, local_addr(2, 2), '0);
    send_cmd(1'b0, local_addr(2, 1), '0);
    drain();
    end_test("CLINT");

    rand_ready = 1'b1;
    for (int k = 0; k < mix_cmds; k++)
    begin
      while (rand_bits(2) == 0)
        step();
      addr = 16'(rand_bits(16));
      op   = 1'(rand_bits(1));
      data = rand_bits(32);
      // Random writes to mtime would break the ordering check
      if (dev_of(addr) == 2)
        op = 1'b0;
      send_cmd(op, addr, data);
    end
    drain();
    repeat (10) step();
    compare_value("response count", dw'(cmd_count), dw'(resp_count));
    for (int d = 0; d < `TILE_NUM_DEV; d++)
      require(exp_q[d].size() == 0, "a device still owes responses at the end of the run");
    end_test("Loopback and back-pressure");

    $display("Checks: %0d passed, %0d failed", checks - errors, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
tile_pkg.sv
mem_dev_if.sv
stream_fifo.sv
dev_ram.sv
tile_cfg.sv
clint_slice.sv
mem_loopback.sv
cmd_router.sv
resp_arbiter.sv
mem_tile.sv
tb_mem_tile.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module tb_mem_tile
	./obj_dir/Vtb_mem_tile | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
